// File: src/rv_pkg.sv
package rv_pkg;

    // datapath and instruction widths
    localparam int XLEN   = 64;
    localparam int ILEN   = 32;
    localparam int NREGS  = 32;
    localparam int REG_AW = 5;

    // major opcodes, full seven bits
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_REG_32 = 7'b0111011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_IMM_32 = 7'b0011011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;

    // funct3 for the integer alu group
    // same codes for register and immediate forms
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // alu operation select
    typedef enum logic [4:0] {
        ADD64 = 5'd0,
        SUB64 = 5'd1,
        SLL64 = 5'd2,
        SRL64 = 5'd3,
        SRA64 = 5'd4,
        ADD32 = 5'd5,
        SUB32 = 5'd6,
        SLL32 = 5'd7,
        SRL32 = 5'd8,
        SRA32 = 5'd9,
        SLT   = 5'd10,
        SLTU  = 5'd11,
        XOR   = 5'd12,
        OR    = 5'd13,
        AND   = 5'd14,
        // operand 2 straight through, lui
        SRC2  = 5'd15
    } alu_op_t;

    // immediate format, one-hot
    typedef enum logic [4:0] {
        IMM_NONE = 5'b00000,
        IMM_I    = 5'b00001,
        IMM_U    = 5'b00010,
        IMM_S    = 5'b00100,
        IMM_J    = 5'b01000,
        IMM_B    = 5'b10000
    } imm_fmt_t;

    // operand muxes in front of the alu
    typedef enum logic {
        SRC1_RS1 = 1'b0,
        SRC1_PC  = 1'b1
    } src1_sel_t;

    typedef enum logic [1:0] {
        SRC2_RS2  = 2'b00,
        SRC2_IMM  = 2'b01,
        SRC2_FOUR = 2'b10
    } src2_sel_t;

    // decoded controls, travels down the pipe
    typedef struct packed {
        src1_sel_t         src1_sel;
        src2_sel_t         src2_sel;
        alu_op_t           alu_op;
        logic              is_jal;
        logic              is_jalr;
        logic              is_brc;
        logic              is_load;
        logic              is_store;
        logic              rd_wen;
        logic [REG_AW-1:0] rd_addr;
        logic              illegal;
    } dec_ctrl_t;

    // id/ex payload
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] imm;
        dec_ctrl_t       ctrl;
    } id_ex_t;

endpackage

// File: src/rv_decoder.sv
`timescale 1ns/1ns

module rv_decoder (
    input  logic [rv_pkg::ILEN-1:0] instr_i,
    output rv_pkg::dec_ctrl_t       ctrl_o,
    output rv_pkg::imm_fmt_t        imm_fmt_o
);

    import rv_pkg::*;

    // instruction fields
    logic [6:0]        opcode;
    logic [2:0]        funct3;
    logic              funct7_b5;
    logic [REG_AW-1:0] rd;
    // bit 3 of the opcode marks the 32-bit W forms
    logic              is_w;

    assign opcode    = instr_i[6:0];
    assign funct3    = instr_i[14:12];
    assign funct7_b5 = instr_i[30];
    assign rd        = instr_i[11:7];
    assign is_w      = instr_i[3];

    // alu op for the integer group shared by R and I forms
    // sub only exists in register form but sra in both
    function automatic alu_op_t alu_sel(
        input logic [2:0] f3,
        input logic       b5,
        input logic       w,
        input logic       reg_form
    );
        alu_op_t op;
        op = ADD64;
        case (f3)
            F3_ADD_SUB: begin
                if (reg_form && b5) begin
                    op = w ? SUB32 : SUB64;
                end else begin
                    op = w ? ADD32 : ADD64;
                end
            end
            F3_SLL: begin
                op = w ? SLL32 : SLL64;
            end
            F3_SLT: begin
                op = SLT;
            end
            F3_SLTU: begin
                op = SLTU;
            end
            F3_XOR: begin
                op = XOR;
            end
            F3_SRL_SRA: begin
                // arithmetic shift picked by funct7 bit 5
                if (b5) begin
                    op = w ? SRA32 : SRA64;
                end else begin
                    op = w ? SRL32 : SRL64;
                end
            end
            F3_OR: begin
                op = OR;
            end
            F3_AND: begin
                op = AND;
            end
        endcase
        return op;
    endfunction

    always_comb begin
        // defaults are add on rs1 and rs2 with no immediate and all flags low
        ctrl_o          = '0;
        ctrl_o.src1_sel = SRC1_RS1;
        ctrl_o.src2_sel = SRC2_RS2;
        ctrl_o.alu_op   = ADD64;
        ctrl_o.rd_addr  = rd;
        imm_fmt_o       = IMM_NONE;
        case (opcode)
            OP_REG, OP_REG_32: begin
                ctrl_o.alu_op = alu_sel(funct3, funct7_b5, is_w, 1'b1);
                ctrl_o.rd_wen = 1'b1;
            end
            OP_IMM, OP_IMM_32: begin
                ctrl_o.alu_op   = alu_sel(funct3, funct7_b5, is_w, 1'b0);
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.rd_wen   = 1'b1;
                imm_fmt_o       = IMM_I;
            end
            OP_LOAD: begin
                // address = rs1 + imm
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.is_load  = 1'b1;
                ctrl_o.rd_wen   = 1'b1;
                imm_fmt_o       = IMM_I;
            end
            OP_STORE: begin
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.is_store = 1'b1;
                imm_fmt_o       = IMM_S;
            end
            OP_BRANCH: begin
                // compare happens on rs1/rs2 later
                ctrl_o.is_brc = 1'b1;
                imm_fmt_o     = IMM_B;
            end
            OP_JAL: begin
                // link value pc + 4
                ctrl_o.src1_sel = SRC1_PC;
                ctrl_o.src2_sel = SRC2_FOUR;
                ctrl_o.is_jal   = 1'b1;
                ctrl_o.rd_wen   = 1'b1;
                imm_fmt_o       = IMM_J;
            end
            OP_JALR: begin
                ctrl_o.src1_sel = SRC1_PC;
                ctrl_o.src2_sel = SRC2_FOUR;
                ctrl_o.is_jalr  = 1'b1;
                ctrl_o.rd_wen   = 1'b1;
                imm_fmt_o       = IMM_I;
            end
            OP_LUI: begin
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.alu_op   = SRC2;
                ctrl_o.rd_wen   = 1'b1;
                imm_fmt_o       = IMM_U;
            end
            OP_AUIPC: begin
                ctrl_o.src1_sel = SRC1_PC;
                ctrl_o.src2_sel = SRC2_IMM;
                ctrl_o.rd_wen   = 1'b1;
                imm_fmt_o       = IMM_U;
            end
            default: begin
                // unknown opcode never writes back
                ctrl_o.illegal = 1'b1;
            end
        endcase
        // writes to x0 dropped here
        if (rd == '0) begin
            ctrl_o.rd_wen = 1'b0;
        end
    end

endmodule

// File: src/imm_gen.sv
`timescale 1ns/1ns

module imm_gen (
    input  logic [rv_pkg::ILEN-1:0] instr_i,
    input  rv_pkg::imm_fmt_t        imm_fmt_i,
    output logic [rv_pkg::XLEN-1:0] imm_o
);

    import rv_pkg::*;

    // sign bit always instruction bit 31
    logic sgn;

    assign sgn = instr_i[31];

    always_comb begin
        case (imm_fmt_i)
            IMM_I: begin
                imm_o = {{(XLEN-12){sgn}}, instr_i[31:20]};
            end
            IMM_S: begin
                imm_o = {{(XLEN-12){sgn}}, instr_i[31:25], instr_i[11:7]};
            end
            IMM_B: begin
                // bit 0 always zero
                imm_o = {{(XLEN-13){sgn}}, instr_i[31], instr_i[7],
                         instr_i[30:25], instr_i[11:8], 1'b0};
            end
            IMM_U: begin
                // upper 20 bits, low 12 zero
                imm_o = {{(XLEN-32){sgn}}, instr_i[31:12], 12'h000};
            end
            IMM_J: begin
                imm_o = {{(XLEN-21){sgn}}, instr_i[31], instr_i[19:12],
                         instr_i[20], instr_i[30:21], 1'b0};
            end
            default: begin
                // IMM_NONE or a broken code
                imm_o = '0;
            end
        endcase
    end

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic [rv_pkg::REG_AW-1:0] rs1_addr_i,
    input  logic [rv_pkg::REG_AW-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0]   rs1_data_o,
    output logic [rv_pkg::XLEN-1:0]   rs2_data_o,
    input  logic                      wb_wen_i,
    input  logic [rv_pkg::REG_AW-1:0] wb_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   wb_data_i
);

    import rv_pkg::*;

    // x1..x31 only, x0 has no storage
    logic [XLEN-1:0] regs_q [1:NREGS-1];

    // one read port: x0, then bypass, then array
    function automatic logic [XLEN-1:0] rd_port(input logic [REG_AW-1:0] addr);
        logic [XLEN-1:0] val;
        if (addr == '0) begin
            val = '0;
        end else if (wb_wen_i && (wb_addr_i == addr)) begin
            // same-cycle write-back seen by decode
            val = wb_data_i;
        end else begin
            val = regs_q[addr];
        end
        return val;
    endfunction

    assign rs1_data_o = rd_port(rs1_addr_i);
    assign rs2_data_o = rd_port(rs2_addr_i);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 1; i < NREGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wb_wen_i && (wb_addr_i != '0)) begin
            regs_q[wb_addr_i] <= wb_data_i;
        end
    end

endmodule

// File: src/id_ex_reg.sv
`timescale 1ns/1ns

module id_ex_reg (
    input  logic           clk,
    input  logic           reset_i,
    input  logic           stall_i,
    input  logic           flush_i,
    input  logic           valid_i,
    input  rv_pkg::id_ex_t data_i,
    output logic           valid_o,
    output rv_pkg::id_ex_t data_o
);

    import rv_pkg::*;

    logic   valid_q;
    id_ex_t data_q;

    // valid bit: reset, flush, stall, load
    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            valid_q <= 1'b0;
        end else if (!stall_i) begin
            valid_q <= valid_i;
        end
    end

    // payload follows the stall only
    // contents after a flush are dont-care
    always_ff @(posedge clk) begin
        if (reset_i) begin
            data_q <= '0;
        end else if (!stall_i) begin
            data_q <= data_i;
        end
    end

    assign valid_o = valid_q;
    assign data_o  = data_q;

endmodule

// File: src/id_stage.sv
`timescale 1ns/1ns

module id_stage (
    input  logic                      clk,
    input  logic                      reset_i,
    // fetch side
    input  logic                      valid_i,
    input  logic [rv_pkg::XLEN-1:0]   pc_i,
    input  logic [rv_pkg::ILEN-1:0]   instr_i,
    // write-back side
    input  logic                      wb_wen_i,
    input  logic [rv_pkg::REG_AW-1:0] wb_addr_i,
    input  logic [rv_pkg::XLEN-1:0]   wb_data_i,
    // hazard control
    input  logic                      stall_i,
    input  logic                      flush_i,
    output logic                      ex_valid_o,
    output rv_pkg::id_ex_t            ex_o
);

    import rv_pkg::*;

    dec_ctrl_t       ctrl;
    imm_fmt_t        imm_fmt;
    logic [XLEN-1:0] imm;
    logic [XLEN-1:0] rs1_data;
    logic [XLEN-1:0] rs2_data;
    id_ex_t          id_d;

    rv_decoder u_decoder (
        .instr_i   (instr_i),
        .ctrl_o    (ctrl),
        .imm_fmt_o (imm_fmt)
    );

    imm_gen u_imm_gen (
        .instr_i   (instr_i),
        .imm_fmt_i (imm_fmt),
        .imm_o     (imm)
    );

    // source register fields straight from the instruction
    reg_file u_reg_file (
        .clk        (clk),
        .reset_i    (reset_i),
        .rs1_addr_i (instr_i[19:15]),
        .rs2_addr_i (instr_i[24:20]),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_wen_i   (wb_wen_i),
        .wb_addr_i  (wb_addr_i),
        .wb_data_i  (wb_data_i)
    );

    // payload for the execute stage
    assign id_d.pc       = pc_i;
    assign id_d.rs1_data = rs1_data;
    assign id_d.rs2_data = rs2_data;
    assign id_d.imm      = imm;
    assign id_d.ctrl     = ctrl;

    id_ex_reg u_id_ex_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (stall_i),
        .flush_i (flush_i),
        .valid_i (valid_i),
        .data_i  (id_d),
        .valid_o (ex_valid_o),
        .data_o  (ex_o)
    );

endmodule

// File: tb/id_model.sv
package id_model;

    import rv_pkg::*;

    // reference state, x0 has no entry
    logic [XLEN-1:0] regs [1:NREGS-1];
    logic            exp_valid;
    id_ex_t          exp_data;

    // decode straight from the isa encoding tables
    function automatic dec_ctrl_t decode_instr(input logic [ILEN-1:0] ins);
        dec_ctrl_t  c;
        logic [6:0] opc;
        logic [2:0] f3;
        logic       reg_form;
        logic       word;
        logic       neg;
        int         w_ofs;
        opc      = ins[6:0];
        f3       = ins[14:12];
        reg_form = (opc == OP_REG) || (opc == OP_REG_32);
        word     = (opc == OP_REG_32) || (opc == OP_IMM_32);
        // sub only in register form, sra in both forms
        neg      = ins[30] && ((f3 == 3'b101) || ((f3 == 3'b000) && reg_form));
        // 32-bit ops sit five codes above the 64-bit ones
        w_ofs    = word ? 5 : 0;
        // all-zero codes: rs1, rs2, add64
        c         = '0;
        c.rd_addr = ins[11:7];
        c.rd_wen  = 1'b1;
        case (opc)
            OP_REG, OP_REG_32, OP_IMM, OP_IMM_32: begin
                if (!reg_form) begin
                    c.src2_sel = SRC2_IMM;
                end
                case (f3)
                    3'b000:  c.alu_op = alu_op_t'((neg ? 1 : 0) + w_ofs);
                    3'b001:  c.alu_op = alu_op_t'(2 + w_ofs);
                    3'b101:  c.alu_op = alu_op_t'((neg ? 4 : 3) + w_ofs);
                    3'b010:  c.alu_op = SLT;
                    3'b011:  c.alu_op = SLTU;
                    3'b100:  c.alu_op = XOR;
                    3'b110:  c.alu_op = OR;
                    default: c.alu_op = AND;
                endcase
            end
            OP_LOAD: begin
                c.src2_sel = SRC2_IMM;
                c.is_load  = 1'b1;
            end
            OP_STORE: begin
                c.src2_sel = SRC2_IMM;
                c.is_store = 1'b1;
                c.rd_wen   = 1'b0;
            end
            OP_BRANCH: begin
                c.is_brc = 1'b1;
                c.rd_wen = 1'b0;
            end
            OP_JAL, OP_JALR: begin
                // link address pc + 4
                c.src1_sel = SRC1_PC;
                c.src2_sel = SRC2_FOUR;
                c.is_jal   = (opc == OP_JAL);
                c.is_jalr  = (opc == OP_JALR);
            end
            OP_LUI: begin
                c.src2_sel = SRC2_IMM;
                c.alu_op   = SRC2;
            end
            OP_AUIPC: begin
                c.src1_sel = SRC1_PC;
                c.src2_sel = SRC2_IMM;
            end
            default: begin
                c.illegal = 1'b1;
                c.rd_wen  = 1'b0;
            end
        endcase
        if (c.rd_addr == '0) begin
            c.rd_wen = 1'b0;
        end
        return c;
    endfunction

    // immediate picked by opcode, sign word sliced for the upper part
    function automatic logic [XLEN-1:0] build_imm(input logic [ILEN-1:0] ins);
        logic [XLEN-1:0] s;
        s = {XLEN{ins[31]}};
        case (ins[6:0])
            OP_IMM, OP_IMM_32, OP_LOAD, OP_JALR: return {s[63:12], ins[31:20]};
            OP_STORE:         return {s[63:12], ins[31:25], ins[11:7]};
            OP_BRANCH:        return {s[63:12], ins[7], ins[30:25], ins[11:8], 1'b0};
            OP_LUI, OP_AUIPC: return {s[63:32], ins[31:12], 12'h000};
            OP_JAL:           return {s[63:20], ins[19:12], ins[20], ins[30:21], 1'b0};
            default:          return '0;
        endcase
    endfunction

    // read with write-back bypass
    function automatic logic [XLEN-1:0] read_reg(input logic [REG_AW-1:0] addr,
                                                 input logic wen,
                                                 input logic [REG_AW-1:0] waddr,
                                                 input logic [XLEN-1:0] wdata);
        if (addr == '0) begin
            return '0;
        end
        if (wen && (waddr == addr)) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    task automatic reset_model();
        exp_valid = 1'b0;
        exp_data  = '0;
        for (int i = 1; i < NREGS; i++) begin
            regs[i] = '0;
        end
    endtask

    // one rising edge of the stage, inputs as sampled at that edge
    task automatic clock_edge(input logic rst, input logic vld, input logic [XLEN-1:0] pc,
                              input logic [ILEN-1:0] ins, input logic wen,
                              input logic [REG_AW-1:0] waddr, input logic [XLEN-1:0] wdata,
                              input logic stall, input logic flush);
        id_ex_t nxt;
        if (rst) begin
            reset_model();
        end else begin
            nxt.pc       = pc;
            nxt.rs1_data = read_reg(ins[19:15], wen, waddr, wdata);
            nxt.rs2_data = read_reg(ins[24:20], wen, waddr, wdata);
            nxt.imm      = build_imm(ins);
            nxt.ctrl     = decode_instr(ins);
            // flush beats stall for the valid bit
            if (flush) begin
                exp_valid = 1'b0;
            end else if (!stall) begin
                exp_valid = vld;
            end
            if (!stall) begin
                exp_data = nxt;
            end
            if (wen && (waddr != '0)) begin
                regs[waddr] = wdata;
            end
        end
    endtask

endpackage

// File: tb/tb_id_stage.sv
`timescale 1ns/1ns

module tb_id_stage;

    import rv_pkg::*;
    import id_model::*;

    localparam int NCYCLES = 4000;

    logic              clk = 1'b0;
    logic              reset_i;
    logic              valid_i;
    logic [XLEN-1:0]   pc_i;
    logic [ILEN-1:0]   instr_i;
    logic              wb_wen_i;
    logic [REG_AW-1:0] wb_addr_i;
    logic [XLEN-1:0]   wb_data_i;
    logic              stall_i;
    logic              flush_i;
    logic              ex_valid_o;
    id_ex_t            ex_o;

    integer seed = 32'h8a253718;
    int     errors = 0;
    int     checks = 0;
    int     cnt;
    logic [6:0] legal_ops [0:10] = '{OP_REG, OP_REG_32, OP_IMM, OP_IMM_32, OP_LOAD,
                                     OP_STORE, OP_BRANCH, OP_JAL, OP_JALR, OP_LUI, OP_AUIPC};

    id_stage DUT (.*);

    always #5 clk = ~clk;

    initial begin
        reset_i = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset_i = 1'b0;
    end

    task automatic check_field(input string name, input logic [XLEN-1:0] got,
                               input logic [XLEN-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check_field("ex_valid_o", ex_valid_o, exp_valid);
        // payload only matters for a live entry
        if (exp_valid) begin
            check_field("pc", ex_o.pc, exp_data.pc);
            check_field("rs1_data", ex_o.rs1_data, exp_data.rs1_data);
            check_field("rs2_data", ex_o.rs2_data, exp_data.rs2_data);
            check_field("imm", ex_o.imm, exp_data.imm);
            check_field("src1_sel", ex_o.ctrl.src1_sel, exp_data.ctrl.src1_sel);
            check_field("src2_sel", ex_o.ctrl.src2_sel, exp_data.ctrl.src2_sel);
            check_field("alu_op", ex_o.ctrl.alu_op, exp_data.ctrl.alu_op);
            check_field("is_jal", ex_o.ctrl.is_jal, exp_data.ctrl.is_jal);
            check_field("is_jalr", ex_o.ctrl.is_jalr, exp_data.ctrl.is_jalr);
            check_field("is_brc", ex_o.ctrl.is_brc, exp_data.ctrl.is_brc);
            check_field("is_load", ex_o.ctrl.is_load, exp_data.ctrl.is_load);
            check_field("is_store", ex_o.ctrl.is_store, exp_data.ctrl.is_store);
            check_field("rd_wen", ex_o.ctrl.rd_wen, exp_data.ctrl.rd_wen);
            check_field("rd_addr", ex_o.ctrl.rd_addr, exp_data.ctrl.rd_addr);
            check_field("illegal", ex_o.ctrl.illegal, exp_data.ctrl.illegal);
        end
    endtask

    task automatic drive_inputs();
        logic [6:0] opc;
        // fetch side frozen while the stage stalls
        if (!stall_i) begin
            opc = legal_ops[$unsigned($random(seed)) % 11];
            // roughly one in twenty is an unknown opcode
            if (($unsigned($random(seed)) % 20) == 0) begin
                opc = 7'h7f;
            end
            instr_i = {$random(seed), opc} >> 7 << 7 | opc;
            valid_i = ($unsigned($random(seed)) % 10) != 0;
            pc_i    = {$random(seed), $random(seed)} & ~64'h3;
        end
        wb_wen_i  = $random(seed);
        wb_addr_i = $random(seed);
        // steer some writes onto rs1 to hit the bypass
        if (($unsigned($random(seed)) % 4) == 0) begin
            wb_addr_i = instr_i[19:15];
        end
        wb_data_i = {$random(seed), $random(seed)};
        stall_i   = ($unsigned($random(seed)) % 100) < 10;
        flush_i   = ($unsigned($random(seed)) % 100) < 5;
    endtask

    initial begin
        valid_i   = 1'b0;
        pc_i      = '0;
        instr_i   = '0;
        wb_wen_i  = 1'b0;
        wb_addr_i = '0;
        wb_data_i = '0;
        stall_i   = 1'b0;
        flush_i   = 1'b0;
        reset_model();
        // reset release, stage must stay empty meanwhile
        cnt = 0;
        while (reset_i !== 1'b0 && cnt < 20) begin
            @(negedge clk);
            cnt++;
            check_field("ex_valid_o in reset", ex_valid_o, 1'b0);
            check_field("ex_o in reset", (ex_o === '0), 1'b1);
        end
        if (reset_i !== 1'b0) begin
            $display("timeout: reset was never released");
            errors++;
        end
        repeat (NCYCLES) begin
            @(posedge clk);
            clock_edge(reset_i, valid_i, pc_i, instr_i, wb_wen_i, wb_addr_i, wb_data_i,
                       stall_i, flush_i);
            #1;
            check_outputs();
            drive_inputs();
        end
        // drain with nothing new coming in
        valid_i  = 1'b0;
        stall_i  = 1'b0;
        flush_i  = 1'b0;
        wb_wen_i = 1'b0;
        cnt = 0;
        while (ex_valid_o !== 1'b0 && cnt < 10) begin
            @(posedge clk);
            #1;
            cnt++;
        end
        if (ex_valid_o !== 1'b0) begin
            $display("timeout: the pipeline register did not drain");
            errors++;
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: src.f
src/rv_pkg.sv
src/rv_decoder.sv
src/imm_gen.sv
src/reg_file.sv
src/id_ex_reg.sv
src/id_stage.sv
tb/id_model.sv
tb/tb_id_stage.sv

// File: Bender.yml
package:
  name: rv_id_stage

sources:
  - src/rv_pkg.sv
  - src/rv_decoder.sv
  - src/imm_gen.sv
  - src/reg_file.sv
  - src/id_ex_reg.sv
  - src/id_stage.sv
  - target: test
    files:
      - tb/id_model.sv
      - tb/tb_id_stage.sv
